// ==== bench/ex_clock_gen.sv ====
//------------------------------------------------
// Testbench clock and reset
// 4 ns clock, reset low for the first two cycles
//------------------------------------------------
`timescale 1ns/1ps

module ex_clock_gen #(
    parameter int PERIOD_NS = 4
) (
    output logic g_clk,
    output logic g_resetn
);

    initial begin
        g_clk    = 1'b0;
        g_resetn = 1'b0;
        repeat (2) @(posedge g_clk);
        g_resetn <= 1'b1;                       // Released after the second edge
    end

    always #(PERIOD_NS / 2) g_clk = ~g_clk;

endmodule

// ==== bench/ex_execute_tb.sv ====
//------------------------------------------------
// Execute stage testbench
// Vector file for ALU, CFU and LSU, random multiplies,
// back-pressure and flush
//------------------------------------------------
`timescale 1ns/1ps

module ex_execute_tb import ex_isa_pkg::*, ex_stage_pkg::*; ();

    localparam int NUM_VEC  = 20;
    localparam int VEC_COLS = 8;                // fu uop a b c exp_a exp_b exp_uop
    localparam int TIMEOUT  = 200;              // Cycles per wait
    localparam int NUM_MUL  = 9;
    localparam int MUL_BITS = 2;

    logic      g_clk;
    logic      g_resetn;
    logic      s2_valid;
    reg_addr_t s2_rd;
    fu_e       s2_fu;
    uop_t      s2_uop;
    word_t     s2_opr_a;
    word_t     s2_opr_b;
    word_t     s2_opr_c;
    logic      s2_busy;
    logic      flush;
    logic      s3_valid;
    reg_addr_t s3_rd;
    fu_e       s3_fu;
    uop_t      s3_uop;
    word_t     s3_opr_a;
    word_t     s3_opr_b;
    logic      s3_busy;

    word_t     vec_mem [0:NUM_VEC*VEC_COLS-1];
    integer    seed;

    ex_clock_gen u_clock_gen (
        .g_clk    (g_clk),
        .g_resetn (g_resetn)
    );

    ex_execute #(
        .MUL_BITS_PER_CYCLE (MUL_BITS)
    ) UUT (
        .g_clk      (g_clk),
        .g_resetn   (g_resetn),
        .i_s2_valid (s2_valid),
        .i_s2_rd    (s2_rd),
        .i_s2_fu    (s2_fu),
        .i_s2_uop   (s2_uop),
        .i_s2_opr_a (s2_opr_a),
        .i_s2_opr_b (s2_opr_b),
        .i_s2_opr_c (s2_opr_c),
        .o_s2_busy  (s2_busy),
        .i_flush    (flush),
        .o_s3_valid (s3_valid),
        .o_s3_rd    (s3_rd),
        .o_s3_fu    (s3_fu),
        .o_s3_uop   (s3_uop),
        .o_s3_opr_a (s3_opr_a),
        .o_s3_opr_b (s3_opr_b),
        .i_s3_busy  (s3_busy)
    );

    // ------------------------------------------------
    // Checks and failure reporting
    // ------------------------------------------------
    task automatic abort_run();
        $display(">>> FAIL");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("error: %s expected %h actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_uop(input string name, input uop_t exp, input uop_t act);
        if (act !== exp) begin
            $display("error: %s expected %h actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_rd(input string name, input reg_addr_t exp, input reg_addr_t act);
        if (act !== exp) begin
            $display("error: %s expected %h actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_fu(input string name, input fu_e exp, input fu_e act);
        if (act !== exp) begin
            $display("error: %s expected %h actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_level(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("error: %s expected %b actual %b", name, exp, act);
            abort_run();
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout: %s", what);
        abort_run();
    endtask

    // ------------------------------------------------
    // Waits, each bounded by its own limit
    // ------------------------------------------------
    task automatic wait_s3_valid(input int limit, input string what);
        int cycles;
        cycles = 0;
        @(negedge g_clk);
        while (s3_valid !== 1'b1) begin
            cycles++;
            if (cycles >= limit) begin
                report_timeout(what);
            end
            @(negedge g_clk);
        end
    endtask

    task automatic wait_busy_low(input int limit, input string what);
        int cycles;
        cycles = 0;
        @(negedge g_clk);
        while (s2_busy !== 1'b0) begin
            cycles++;
            if (cycles >= limit) begin
                report_timeout(what);
            end
            @(negedge g_clk);
        end
    endtask

    // ------------------------------------------------
    // Stimulus
    // ------------------------------------------------
    task automatic load_vector(input int idx);
        int base;
        base     = idx * VEC_COLS;
        s2_valid = 1'b1;
        s2_rd    = reg_addr_t'(idx);
        s2_fu    = fu_e'(vec_mem[base][2:0]);
        s2_uop   = uop_t'(vec_mem[base+1][4:0]);
        s2_opr_a = vec_mem[base+2];
        s2_opr_b = vec_mem[base+3];
        s2_opr_c = vec_mem[base+4];
    endtask

    task automatic check_vector(input string name, input int idx);
        int base;
        base = idx * VEC_COLS;
        check_rd({name, " rd"}, reg_addr_t'(idx), s3_rd);
        check_fu({name, " fu"}, fu_e'(vec_mem[base][2:0]), s3_fu);
        check_word({name, " opr_a"}, vec_mem[base+5], s3_opr_a);
        check_word({name, " opr_b"}, vec_mem[base+6], s3_opr_b);
        check_uop({name, " uop"}, uop_t'(vec_mem[base+7][4:0]), s3_uop);
    endtask

    task automatic run_vector(input int idx);
        string name;
        name = $sformatf("vector %0d", idx);
        @(negedge g_clk);
        load_vector(idx);
        #1;                                     // Let the stall settle
        check_level({name, " s2_busy"}, 1'b0, s2_busy);
        wait_s3_valid(1, {name, " gave no o_s3_valid one cycle after acceptance"});
        s2_valid = 1'b0;
        check_vector(name, idx);
    endtask

    // Full 64-bit product, signed for MULH only
    function automatic logic [63:0] product_of(input mul_op_e op, input word_t a,
                                               input word_t b);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        sa = {{32{a[31]}}, a};
        sb = {{32{b[31]}}, b};
        if (op == MUL_MULH) begin
            return sa * sb;
        end
        return {32'b0, a} * {32'b0, b};
    endfunction

    task automatic present_multiply(input mul_op_e op, input reg_addr_t rd, input word_t a,
                                    input word_t b);
        s2_valid = 1'b1;
        s2_rd    = rd;
        s2_fu    = FU_MUL;
        s2_uop   = uop_t'(op);
        s2_opr_a = a;
        s2_opr_b = b;
        s2_opr_c = '0;
    endtask

    task automatic run_multiply(input string name, input mul_op_e op, input reg_addr_t rd,
                                input word_t a, input word_t b);
        logic [63:0] prod;
        prod = product_of(op, a, b);
        @(negedge g_clk);
        present_multiply(op, rd, a, b);
        #1;
        check_level({name, " s2_busy rise"}, 1'b1, s2_busy);
        wait_busy_low(TIMEOUT, {name, " never dropped o_s2_busy"});
        wait_s3_valid(TIMEOUT, {name, " never raised o_s3_valid"});
        s2_valid = 1'b0;
        check_rd({name, " rd"}, rd, s3_rd);
        check_fu({name, " fu"}, FU_MUL, s3_fu);
        check_word({name, " opr_a"}, (op == MUL_MUL) ? prod[31:0] : prod[63:32], s3_opr_a);
        check_word({name, " opr_b"}, prod[63:32], s3_opr_b);
        check_uop({name, " uop"}, uop_t'(op), s3_uop);
    endtask

    // Stage 3 stalls with a result held, next instruction waits
    task automatic check_backpressure();
        @(negedge g_clk);
        s3_busy = 1'b1;
        load_vector(0);
        wait_s3_valid(1, "held result gave no o_s3_valid after acceptance");
        load_vector(1);                         // Waits in stage 2
        #1;
        check_level("backpressure s2_busy", 1'b1, s2_busy);
        repeat (4) begin
            @(negedge g_clk);
            check_level("backpressure s3_valid", 1'b1, s3_valid);
            check_level("backpressure s2_busy", 1'b1, s2_busy);
            check_vector("backpressure held", 0);
        end
        s3_busy = 1'b0;
        @(negedge g_clk);                       // Waiting instruction taken
        s2_valid = 1'b0;
        check_level("backpressure release s3_valid", 1'b1, s3_valid);
        check_vector("backpressure release", 1);
    endtask

    // Flush a held result and a multiply in progress
    task automatic check_flush();
        word_t a;
        word_t b;
        a = $random(seed);
        b = $random(seed);
        @(negedge g_clk);
        s3_busy = 1'b1;
        load_vector(2);
        wait_s3_valid(1, "flush setup gave no o_s3_valid after acceptance");
        present_multiply(MUL_MULH, 5'd30, a, b);
        #1;
        check_level("flush multiply s2_busy", 1'b1, s2_busy);
        repeat (3) @(negedge g_clk);            // Multiply part way through
        flush    = 1'b1;
        s2_valid = 1'b0;
        @(negedge g_clk);
        flush    = 1'b0;
        s3_busy  = 1'b0;
        check_level("flush s3_valid", 1'b0, s3_valid);
        check_rd("flush rd", '0, s3_rd);
        check_fu("flush fu", FU_NONE, s3_fu);
        check_uop("flush uop", '0, s3_uop);
        check_word("flush opr_a", '0, s3_opr_a);
        check_word("flush opr_b", '0, s3_opr_b);
        repeat (2 * (32 / MUL_BITS + 1)) begin  // No late product
            @(negedge g_clk);
            check_level("after flush s3_valid", 1'b0, s3_valid);
            check_level("after flush s2_busy", 1'b0, s2_busy);
        end
    endtask

    // ------------------------------------------------
    // Main sequence
    // ------------------------------------------------
    initial begin
        int      cycles;
        mul_op_e op;
        word_t   a;
        word_t   b;

        s2_valid = 1'b0;
        s2_rd    = '0;
        s2_fu    = FU_NONE;
        s2_uop   = '0;
        s2_opr_a = '0;
        s2_opr_b = '0;
        s2_opr_c = '0;
        flush    = 1'b0;
        s3_busy  = 1'b0;
        seed     = 32'h9a92_d218;

        $readmemh("bench/ex_vectors_input.txt", vec_mem);
        if ($isunknown(vec_mem[NUM_VEC*VEC_COLS-1])) begin
            $display("could not read the full vector file bench/ex_vectors_input.txt");
            abort_run();
        end

        cycles = 0;
        while (g_resetn !== 1'b1) begin
            @(negedge g_clk);
            cycles++;
            if (g_resetn !== 1'b1 && cycles >= TIMEOUT) begin
                report_timeout("g_resetn was never released");
            end
        end
        @(negedge g_clk);
        check_level("reset s3_valid", 1'b0, s3_valid);
        check_level("reset s2_busy", 1'b0, s2_busy);

        for (int i = 0; i < NUM_VEC; i++) begin
            run_vector(i);
        end

        for (int i = 0; i < NUM_MUL; i++) begin
            op = mul_op_e'(uop_t'(i % 3));       // MUL, MULH, MULHU in turn
            a  = $random(seed);
            b  = $random(seed);
            run_multiply($sformatf("multiply %0d", i), op, reg_addr_t'(i + 1), a, b);
        end

        check_backpressure();
        check_flush();

        a = $random(seed);
        b = $random(seed);
        run_multiply("multiply after flush", MUL_MULHU, 5'd31, a, b);

        $display(">>> PASS");
        $finish;
    end

endmodule

// ==== bench/ex_vectors_input.txt ====
// fu uop opr_a opr_b opr_c exp_opr_a exp_opr_b exp_uop (hex)
// fu: 1 ALU, 3 LSU, 4 CFU
1 00 00001234 00000010 00000000 00001244 00000000 00
1 01 00000005 00000007 00000000 fffffffe 00000000 01
1 02 ff00ff00 0ff00ff0 00000000 f0f0f0f0 00000000 02
1 03 12340000 00005678 00000000 12345678 00000000 03
1 04 ff00ff00 0ff00ff0 00000000 0f000f00 00000000 04
1 05 00000001 00000024 00000000 00000010 00000000 05
1 06 80000000 0000001f 00000000 00000001 00000000 06
1 07 80000000 00000004 00000000 f8000000 00000000 07
1 08 ffffffff 00000001 00000000 00000001 00000000 08
1 09 ffffffff 00000001 00000000 00000000 00000000 09
4 01 00000007 00000007 00001001 00001000 00000000 19
4 02 00000007 00000007 00002003 00002002 00000000 1a
4 03 ffffffff 00000001 00000100 00000100 00000000 19
4 05 ffffffff 00000001 00000104 00000104 00000000 1a
4 04 00000001 ffffffff 00000200 00000200 00000000 19
4 06 00000001 ffffffff 00000201 00000200 00000000 1a
4 11 00000010 00000020 00003005 00003004 00000000 11
4 12 00001001 00000010 00000000 00001010 00000000 12
3 01 00001000 00000024 deadbeef 00001024 00000000 01
3 02 00002000 fffffffc cafef00d 00001ffc cafef00d 02

// ==== common/ex_isa_pkg.sv ====
//------------------------------------------------
// Execute stage ISA encodings
// Functional units and the micro-op codes of each unit
//------------------------------------------------
package ex_isa_pkg;

    typedef enum logic [2:0] {
        FU_NONE = 3'd0,                         // Bubble, no unit
        FU_ALU  = 3'd1,
        FU_MUL  = 3'd2,
        FU_LSU  = 3'd3,
        FU_CFU  = 3'd4
    } fu_e;

    typedef enum logic [4:0] {
        ALU_ADD  = 5'd0,
        ALU_SUB  = 5'd1,
        ALU_XOR  = 5'd2,
        ALU_OR   = 5'd3,
        ALU_AND  = 5'd4,
        ALU_SLL  = 5'd5,
        ALU_SRL  = 5'd6,
        ALU_SRA  = 5'd7,
        ALU_SLT  = 5'd8,
        ALU_SLTU = 5'd9
    } alu_op_e;

    typedef enum logic [4:0] {
        MUL_MUL   = 5'd0,                       // Low half
        MUL_MULH  = 5'd1,                       // Signed high half
        MUL_MULHU = 5'd2                        // Unsigned high half
    } mul_op_e;

    // Bits 4:3 give the class: 00 branch, 10 jump, 11 outcome
    typedef enum logic [4:0] {
        CFU_BEQ       = 5'b00_001,
        CFU_BNE       = 5'b00_010,
        CFU_BLT       = 5'b00_011,
        CFU_BGE       = 5'b00_100,
        CFU_BLTU      = 5'b00_101,
        CFU_BGEU      = 5'b00_110,
        CFU_JAL       = 5'b10_001,
        CFU_JALR      = 5'b10_010,
        CFU_TAKEN     = 5'b11_001,
        CFU_NOT_TAKEN = 5'b11_010
    } cfu_op_e;

    typedef enum logic [4:0] {
        LSU_LOAD  = 5'd1,
        LSU_STORE = 5'd2
    } lsu_op_e;

endpackage

// ==== common/ex_stage_pkg.sv ====
//------------------------------------------------
// Execute stage datapath types
// Words, register addresses and raw micro-ops
//------------------------------------------------
package ex_stage_pkg;

    localparam int XLEN = 32;                   // Datapath width

    typedef logic [XLEN-1:0] word_t;            // Operand or result
    typedef logic [4:0]      reg_addr_t;        // Destination register
    typedef logic [4:0]      uop_t;             // Raw micro-op, cast per unit

endpackage

// ==== common/ex_unit_if.sv ====
//------------------------------------------------
// Unit issue bundle
// Operands and micro-op from control to the units
//------------------------------------------------
`timescale 1ns/1ps

interface ex_unit_if import ex_stage_pkg::*; ();

    word_t opr_a;                               // Operand A
    word_t opr_b;                               // Operand B
    word_t opr_c;                               // Operand C, store data or PC target
    uop_t  uop;                                 // Micro-op code

    modport issue (
        output opr_a, opr_b, opr_c, uop
    );

    modport unit (
        input  opr_a, opr_b, opr_c, uop
    );

endinterface

// ==== ex_execute.f ====
common/ex_isa_pkg.sv
common/ex_stage_pkg.sv
common/ex_unit_if.sv
logic/ex_control.sv
logic/ex_alu.sv
logic/ex_branch.sv
multiplier/ex_multiplier.sv
logic/ex_stage_reg.sv
logic/ex_execute.sv
bench/ex_clock_gen.sv
bench/ex_execute_tb.sv

// ==== logic/ex_alu.sv ====
//------------------------------------------------
// Integer ALU
// Single cycle logic, shifts and compares
//------------------------------------------------
`timescale 1ns/1ps

module ex_alu import ex_isa_pkg::*, ex_stage_pkg::*; (
    ex_unit_if.unit u_unit,
    output word_t   o_result,
    output word_t   o_sum                       // Adder out for LSU and CFU
);

    alu_op_e    op;
    logic [4:0] shamt;
    word_t      lhs;
    word_t      rhs;

    assign op    = alu_op_e'(u_unit.uop);
    assign lhs   = u_unit.opr_a;
    assign rhs   = u_unit.opr_b;
    assign shamt = rhs[4:0];

    assign o_sum = lhs + rhs;                   // Shared with address formation

    always_comb begin
        case (op)
            ALU_ADD:  o_result = o_sum;
            ALU_SUB:  o_result = lhs - rhs;
            ALU_XOR:  o_result = lhs ^ rhs;
            ALU_OR:   o_result = lhs | rhs;
            ALU_AND:  o_result = lhs & rhs;
            ALU_SLL:  o_result = lhs << shamt;
            ALU_SRL:  o_result = lhs >> shamt;
            ALU_SRA:  o_result = word_t'($signed(lhs) >>> shamt);
            ALU_SLT:  o_result = {31'b0, $signed(lhs) < $signed(rhs)};
            ALU_SLTU: o_result = {31'b0, lhs < rhs};
            default:  o_result = '0;
        endcase
    end

endmodule

// ==== logic/ex_branch.sv ====
//------------------------------------------------
// Control-flow unit
// Branch compare, taken rewrite and jump targets
//------------------------------------------------
`timescale 1ns/1ps

module ex_branch import ex_isa_pkg::*, ex_stage_pkg::*; (
    ex_unit_if.unit u_unit,
    input  word_t   i_sum,                      // opr_a + opr_b from ALU
    output uop_t    o_uop,
    output word_t   o_target
);

    cfu_op_e op;
    logic    is_cond;
    logic    eq;
    logic    lt_s;
    logic    lt_u;
    logic    taken;

    assign op      = cfu_op_e'(u_unit.uop);
    assign is_cond = u_unit.uop[4:3] == 2'b00;

    assign eq      = u_unit.opr_a == u_unit.opr_b;
    assign lt_s    = $signed(u_unit.opr_a) < $signed(u_unit.opr_b);
    assign lt_u    = u_unit.opr_a < u_unit.opr_b;

    always_comb begin
        case (op)
            CFU_BEQ:  taken = eq;
            CFU_BNE:  taken = !eq;
            CFU_BLT:  taken = lt_s;
            CFU_BGE:  taken = !lt_s;
            CFU_BLTU: taken = lt_u;
            CFU_BGEU: taken = !lt_u;
            default:  taken = 1'b0;
        endcase
    end

    // Jumps keep their own code
    assign o_uop    = !is_cond ? u_unit.uop       :
                      taken    ? uop_t'(CFU_TAKEN) : uop_t'(CFU_NOT_TAKEN);

    assign o_target = (op == CFU_JALR) ? {i_sum[31:1], 1'b0} : {u_unit.opr_c[31:1], 1'b0};

endmodule

// ==== logic/ex_control.sv ====
//------------------------------------------------
// Execute stage control
// Unit decode, stall, multiplier sequencing and result select
//------------------------------------------------
`timescale 1ns/1ps

module ex_control import ex_isa_pkg::*, ex_stage_pkg::*; #(
    parameter int MUL_BITS_PER_CYCLE = 2
) (
    input  logic        g_clk,
    input  logic        g_resetn,
    input  logic        i_s2_valid,             // Stage 2 holds an instruction
    input  fu_e         i_s2_fu,
    input  uop_t        i_s2_uop,
    input  word_t       i_s2_opr_a,
    input  word_t       i_s2_opr_b,
    input  word_t       i_s2_opr_c,
    input  logic        i_flush,
    input  logic        i_s3_busy,
    input  logic        i_s3_valid,
    input  word_t       i_alu_result,
    input  word_t       i_alu_sum,
    input  uop_t        i_br_uop,
    input  word_t       i_br_target,
    input  logic        i_mul_done,
    input  logic [63:0] i_mul_product,
    output logic        o_s2_busy,
    output logic        o_mul_start,
    output logic        o_mul_clear,
    output logic        o_load,                 // Payload and opr_a enable
    output logic        o_load_b,               // opr_b enable
    output word_t       o_next_opr_a,
    output word_t       o_next_opr_b,
    output uop_t        o_next_uop,
    ex_unit_if.issue    u_unit
);

    localparam int MUL_CYCLES = 32 / MUL_BITS_PER_CYCLE + 1;
    localparam int COUNT_W    = $clog2(MUL_CYCLES + 1);

    logic               p_busy;                 // Stage 3 holding
    logic               accept;
    logic               mul_started;
    logic [COUNT_W-1:0] mul_count;              // Elapsed multiply cycles
    logic               is_store;
    logic               mul_low;

    assign u_unit.opr_a = i_s2_opr_a;
    assign u_unit.opr_b = i_s2_opr_b;
    assign u_unit.opr_c = i_s2_opr_c;
    assign u_unit.uop   = i_s2_uop;

    // ------------------------------------------------
    // Stall and progress
    // ------------------------------------------------
    assign p_busy    = i_s3_valid && i_s3_busy;
    assign o_s2_busy = p_busy || (i_s2_valid && i_s2_fu == FU_MUL && !i_mul_done);
    assign accept    = i_s2_valid && !o_s2_busy;

    assign is_store  = i_s2_fu == FU_LSU && lsu_op_e'(i_s2_uop) == LSU_STORE;
    assign mul_low   = mul_op_e'(i_s2_uop) == MUL_MUL;

    assign o_load    = accept;
    assign o_load_b  = accept && i_s2_fu != FU_NONE;    // Bubbles keep opr_b

    // ------------------------------------------------
    // Multiplier sequencing
    // ------------------------------------------------
    assign mul_started = mul_count != '0;
    assign o_mul_start = i_s2_valid && i_s2_fu == FU_MUL && !mul_started;
    assign o_mul_clear = accept || i_flush;

    always_ff @(posedge g_clk) begin
        if (!g_resetn || o_mul_clear) begin
            mul_count <= '0;
        end else if (o_mul_start) begin
            mul_count <= COUNT_W'(1);
        end else if (mul_started && mul_count != COUNT_W'(MUL_CYCLES)) begin
            mul_count <= mul_count + COUNT_W'(1);   // Saturates at full length
        end
    end

    // ------------------------------------------------
    // Result select
    // ------------------------------------------------
    always_comb begin
        case (i_s2_fu)
            FU_ALU:  o_next_opr_a = i_alu_result;
            FU_MUL:  o_next_opr_a = mul_low ? i_mul_product[31:0] : i_mul_product[63:32];
            FU_LSU:  o_next_opr_a = i_alu_sum;      // Memory address
            FU_CFU:  o_next_opr_a = i_br_target;
            default: o_next_opr_a = '0;
        endcase
    end

    assign o_next_opr_b = (i_s2_fu == FU_MUL) ? i_mul_product[63:32] :
                          is_store             ? i_s2_opr_c           :
                                                 '0;

    assign o_next_uop   = (i_s2_fu == FU_CFU) ? i_br_uop : i_s2_uop;

endmodule

// ==== logic/ex_execute.sv ====
//------------------------------------------------
// Execute stage top level
// Control, ALU, CFU, multiplier and stage 3 register
//------------------------------------------------
`timescale 1ns/1ps

module ex_execute import ex_isa_pkg::*, ex_stage_pkg::*; #(
    parameter int MUL_BITS_PER_CYCLE = 2
) (
    input  logic      g_clk,
    input  logic      g_resetn,
    input  logic      i_s2_valid,
    input  reg_addr_t i_s2_rd,
    input  fu_e       i_s2_fu,
    input  uop_t      i_s2_uop,
    input  word_t     i_s2_opr_a,
    input  word_t     i_s2_opr_b,
    input  word_t     i_s2_opr_c,
    output logic      o_s2_busy,
    input  logic      i_flush,
    output logic      o_s3_valid,
    output reg_addr_t o_s3_rd,
    output fu_e       o_s3_fu,
    output uop_t      o_s3_uop,
    output word_t     o_s3_opr_a,
    output word_t     o_s3_opr_b,
    input  logic      i_s3_busy
);

    word_t       alu_result;
    word_t       alu_sum;
    uop_t        br_uop;
    word_t       br_target;
    logic        mul_start;
    logic        mul_clear;
    logic        mul_done;
    logic [63:0] mul_product;
    logic        load;
    logic        load_b;
    word_t       next_opr_a;
    word_t       next_opr_b;
    uop_t        next_uop;

    ex_unit_if unit_bus ();

    ex_control #(
        .MUL_BITS_PER_CYCLE (MUL_BITS_PER_CYCLE)
    ) u_control (
        .g_clk         (g_clk),
        .g_resetn      (g_resetn),
        .i_s2_valid    (i_s2_valid),
        .i_s2_fu       (i_s2_fu),
        .i_s2_uop      (i_s2_uop),
        .i_s2_opr_a    (i_s2_opr_a),
        .i_s2_opr_b    (i_s2_opr_b),
        .i_s2_opr_c    (i_s2_opr_c),
        .i_flush       (i_flush),
        .i_s3_busy     (i_s3_busy),
        .i_s3_valid    (o_s3_valid),
        .i_alu_result  (alu_result),
        .i_alu_sum     (alu_sum),
        .i_br_uop      (br_uop),
        .i_br_target   (br_target),
        .i_mul_done    (mul_done),
        .i_mul_product (mul_product),
        .o_s2_busy     (o_s2_busy),
        .o_mul_start   (mul_start),
        .o_mul_clear   (mul_clear),
        .o_load        (load),
        .o_load_b      (load_b),
        .o_next_opr_a  (next_opr_a),
        .o_next_opr_b  (next_opr_b),
        .o_next_uop    (next_uop),
        .u_unit        (unit_bus)
    );

    ex_alu u_alu (
        .u_unit   (unit_bus),
        .o_result (alu_result),
        .o_sum    (alu_sum)
    );

    ex_branch u_branch (
        .u_unit   (unit_bus),
        .i_sum    (alu_sum),
        .o_uop    (br_uop),
        .o_target (br_target)
    );

    ex_multiplier #(
        .MUL_BITS_PER_CYCLE (MUL_BITS_PER_CYCLE)
    ) u_multiplier (
        .g_clk     (g_clk),
        .g_resetn  (g_resetn),
        .u_unit    (unit_bus),
        .i_start   (mul_start),
        .i_clear   (mul_clear),
        .o_done    (mul_done),
        .o_product (mul_product)
    );

    ex_stage_reg u_stage_reg (
        .g_clk     (g_clk),
        .g_resetn  (g_resetn),
        .i_flush   (i_flush),
        .i_s3_busy (i_s3_busy),
        .i_load    (load),
        .i_load_b  (load_b),
        .i_rd      (i_s2_rd),
        .i_fu      (i_s2_fu),
        .i_uop     (next_uop),
        .i_opr_a   (next_opr_a),
        .i_opr_b   (next_opr_b),
        .o_valid   (o_s3_valid),
        .o_rd      (o_s3_rd),
        .o_fu      (o_s3_fu),
        .o_uop     (o_s3_uop),
        .o_opr_a   (o_s3_opr_a),
        .o_opr_b   (o_s3_opr_b)
    );

endmodule

// ==== logic/ex_stage_reg.sv ====
//------------------------------------------------
// Stage 3 pipeline register
// Payload with separate opr_b enable and flush
//------------------------------------------------
`timescale 1ns/1ps

module ex_stage_reg import ex_isa_pkg::*, ex_stage_pkg::*; (
    input  logic      g_clk,
    input  logic      g_resetn,
    input  logic      i_flush,
    input  logic      i_s3_busy,
    input  logic      i_load,                   // Payload and opr_a
    input  logic      i_load_b,                 // opr_b only
    input  reg_addr_t i_rd,
    input  fu_e       i_fu,
    input  uop_t      i_uop,
    input  word_t     i_opr_a,
    input  word_t     i_opr_b,
    output logic      o_valid,
    output reg_addr_t o_rd,
    output fu_e       o_fu,
    output uop_t      o_uop,
    output word_t     o_opr_a,
    output word_t     o_opr_b
);

    always_ff @(posedge g_clk) begin
        if (!g_resetn || i_flush) begin
            o_valid <= 1'b0;
            o_rd    <= '0;
            o_fu    <= FU_NONE;
            o_uop   <= '0;
            o_opr_a <= '0;
            o_opr_b <= '0;                      // Flush loads zero
        end else begin
            if (i_load) begin
                o_valid <= 1'b1;
                o_rd    <= i_rd;
                o_fu    <= i_fu;
                o_uop   <= i_uop;
                o_opr_a <= i_opr_a;
            end else if (!i_s3_busy) begin
                o_valid <= 1'b0;                // Consumed by stage 3
            end
            if (i_load_b) begin
                o_opr_b <= i_opr_b;
            end
        end
    end

endmodule

// ==== multiplier/ex_multiplier.sv ====
//------------------------------------------------
// Iterative multiplier
// Shift-add over operand magnitudes, 64-bit product
//------------------------------------------------
`timescale 1ns/1ps

module ex_multiplier import ex_isa_pkg::*, ex_stage_pkg::*; #(
    parameter int MUL_BITS_PER_CYCLE = 2
) (
    input  logic        g_clk,
    input  logic        g_resetn,
    ex_unit_if.unit     u_unit,
    input  logic        i_start,                // Load operands
    input  logic        i_clear,                // Back to idle
    output logic        o_done,
    output logic [63:0] o_product
);

    localparam int STEPS = 32 / MUL_BITS_PER_CYCLE;
    localparam int CNT_W = $clog2(STEPS);

    mul_op_e           op;
    logic              is_signed;
    word_t             a_mag;
    word_t             b_mag;
    logic              running;
    logic [CNT_W-1:0]  count;
    logic [63:0]       acc;                     // Partial product
    logic [63:0]       mcand;                   // Shifts left each step
    word_t             mplier;                  // Shifts right each step
    logic              neg;                     // Result sign for MULH
    logic [63:0]       step_add;

    assign op        = mul_op_e'(u_unit.uop);
    assign is_signed = op == MUL_MULH;
    assign a_mag     = (is_signed && u_unit.opr_a[31]) ? -u_unit.opr_a : u_unit.opr_a;
    assign b_mag     = (is_signed && u_unit.opr_b[31]) ? -u_unit.opr_b : u_unit.opr_b;

    // Multiplicand times the low multiplier bits
    always_comb begin
        step_add = '0;
        for (int i = 0; i < MUL_BITS_PER_CYCLE; i++) begin
            if (mplier[i]) begin
                step_add = step_add + (mcand << i);
            end
        end
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn || i_clear) begin
            running <= 1'b0;
            o_done  <= 1'b0;
            count   <= '0;
        end else if (i_start) begin
            running <= 1'b1;
            o_done  <= 1'b0;
            count   <= '0;
        end else if (running) begin
            count <= count + CNT_W'(1);
            if (count == CNT_W'(STEPS - 1)) begin
                running <= 1'b0;                // Last step retired
                o_done  <= 1'b1;
            end
        end
    end

    always_ff @(posedge g_clk) begin
        if (i_start) begin
            acc    <= '0;
            mcand  <= {32'b0, a_mag};
            mplier <= b_mag;
            neg    <= is_signed && (u_unit.opr_a[31] ^ u_unit.opr_b[31]);
        end else if (running) begin
            acc    <= acc + step_add;
            mcand  <= mcand << MUL_BITS_PER_CYCLE;
            mplier <= mplier >> MUL_BITS_PER_CYCLE;
        end
    end

    assign o_product = neg ? -acc : acc;

endmodule

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f ex_execute.f --top-module ex_execute_tb -Mdir obj_dir

output=$(./obj_dir/Vex_execute_tb 2>&1) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -q '^>>> PASS$'; then
    exit 0
else
    exit 1
fi
